// File: bench/rx_buffer_tb_check.svh
`ifndef RX_BUFFER_TB_CHECK_SVH
`define RX_BUFFER_TB_CHECK_SVH

// --------------------------------------------------
// Reference model of the access port
// --------------------------------------------------

// Bytes delivered for each requested size
function automatic int read_length(input word_size_t size);
  case (size)
    SIZE_8:  return 1;
    SIZE_16: return 2;
    SIZE_32: return 4;
    default: return 8;
  endcase
endfunction

// Bytes in address order with the last byte at the low end and upper bytes zero
// Byte 0 of a word sits in bits 63:56 and the address wraps with the RAM
function automatic word_t expected_read(input logic [10:0] byte_addr, input word_size_t size);
  int          count;
  int          i;
  int          bit_pos;
  logic [10:0] a;
  logic [7:0]  b;
  word_t       result;
  count  = read_length(size);
  result = '0;
  for (i = 0; i < count; i++) begin
    a       = byte_addr + 11'(i);
    bit_pos = 8 * (7 - int'(a[2:0]));
    b       = shadow[a[10:3]][bit_pos +: 8];
    result  = {result[55:0], b};
  end
  return result;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

task automatic check_word(input string what, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("ERROR at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    error_count++;
  end
endtask

task automatic check_count(input string what, input int got, input int exp);
  if (got != exp) begin
    $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    error_count++;
  end
endtask

task automatic check_level(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    error_count++;
  end
endtask

`endif

// File: bench/rx_buffer_tb.sv
`timescale 1ns/1ns

module rx_buffer_tb import rx_buffer_pkg::*; ();

  localparam int          ADDR_WIDTH     = 8;
  localparam int          TIMEOUT_CYCLES = 100;
  localparam int unsigned SEED           = 32'hf5d3_4405;

  logic                  clk;
  logic                  areset;
  logic                  parser_busy;
  logic                  packet_available;
  logic                  packet_read;
  logic                  fifo_empty;
  logic                  fifo_rd_en;
  word_t                 fifo_rd_data;
  logic                  access_wait;
  logic [ADDR_WIDTH+2:0] access_addr;
  word_size_t            access_size;
  logic                  access_rd_en;
  logic                  access_dv;
  word_t                 access_data;

  // FIFO model and the RAM contents a correct load leaves behind
  word_t fifo_q[$];
  word_t popped;
  word_t shadow [2**ADDR_WIDTH];
  int    pop_count;
  int    read_pulses;
  int    error_count;
  int    test_errors;
  int    test_num;
  int    reads_done;

  `include "rx_buffer_tb_check.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  rx_buffer_top #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_dut (
    .i_clk                       (clk),
    .i_areset                    (areset),
    .i_parser_busy               (parser_busy),
    .i_dispatch_packet_available (packet_available),
    .o_dispatch_packet_read      (packet_read),
    .i_dispatch_fifo_empty       (fifo_empty),
    .o_dispatch_fifo_rd_en       (fifo_rd_en),
    .i_dispatch_fifo_rd_data     (fifo_rd_data),
    .o_access_port_wait          (access_wait),
    .i_access_port_addr          (access_addr),
    .i_access_port_wordsize      (access_size),
    .i_access_port_rd_en         (access_rd_en),
    .o_access_port_rd_dv         (access_dv),
    .o_access_port_rd_data       (access_data)
  );

  // --------------------------------------------------
  // FIFO model
  // --------------------------------------------------

  function automatic void refresh_fifo();
    fifo_empty   = (fifo_q.size() == 0);
    fifo_rd_data = fifo_empty ? '0 : fifo_q[0];
  endfunction

  // Pop on rd_en at the edge, then present the new head word
  always @(posedge clk) begin
    if (fifo_rd_en) begin
      popped = fifo_q.pop_front();
      pop_count++;
    end
    if (packet_read) begin
      read_pulses++;
    end
    #1;
    refresh_fifo();
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d, %s: %0d errors", test_num, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // Queue a packet, hold the parser busy for a while, then wait for its end
  task automatic load_packet(input int n_words, input int busy_cycles);
    int    i;
    int    cycles;
    int    pulses_before;
    int    pops_before;
    word_t word;
    pulses_before = read_pulses;
    pops_before   = pop_count;
    for (i = 0; i < n_words; i++) begin
      word = {$urandom, $urandom};
      fifo_q.push_back(word);
      shadow[i] = word;
    end
    refresh_fifo();
    parser_busy      = (busy_cycles > 0);
    packet_available = 1'b1;
    if (busy_cycles > 0) begin
      for (i = 0; i < busy_cycles; i++) begin
        next_cycle();
      end
      check_count("words popped while busy", pop_count - pops_before, 0);
      check_count("packet reads while busy", read_pulses - pulses_before, 0);
      parser_busy = 1'b0;
    end
    cycles = 0;
    while (read_pulses == pulses_before && cycles < TIMEOUT_CYCLES) begin
      next_cycle();
      cycles++;
    end
    if (read_pulses == pulses_before) begin
      stop_on_timeout("the end of the packet");
    end
    packet_available = 1'b0;
    repeat (4) next_cycle();
    check_count("packet read pulses", read_pulses - pulses_before, 1);
    check_count("words popped", pop_count - pops_before, n_words);
    check_count("words left in the FIFO", fifo_q.size(), 0);
  endtask

  // One request, then wait for dv and check data, latency and wait
  task automatic read_and_check(input logic [ADDR_WIDTH+2:0] addr, input word_size_t size);
    int    cycles;
    int    low_wait;
    int    latency;
    word_t got;
    latency      = (int'(addr[2:0]) + read_length(size) > 8) ? 3 : 2;
    access_addr  = addr;
    access_size  = size;
    access_rd_en = 1'b1;
    next_cycle();
    access_rd_en = 1'b0;
    cycles       = 0;
    low_wait     = 0;
    while (access_dv !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      if (access_wait !== 1'b1) begin
        low_wait++;
      end
      next_cycle();
      cycles++;
    end
    if (access_dv !== 1'b1) begin
      stop_on_timeout("read data");
    end
    got = access_data;
    check_word($sformatf("%0d-byte read at byte %0d", read_length(size), addr), got,
               expected_read(addr, size));
    check_count("cycles from request to dv", cycles, latency);
    check_count("cycles with wait low before dv", low_wait, 0);
    check_level("wait at dv", access_wait, 1'b0);
    next_cycle();
    check_level("dv one cycle later", access_dv, 1'b0);
    check_word("held read data", access_data, got);
    reads_done++;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int         i;
    int         s;
    int         off;
    word_size_t size;
    void'($urandom(SEED));
    areset           = 1'b1;
    parser_busy      = 1'b0;
    packet_available = 1'b0;
    access_rd_en     = 1'b0;
    access_addr      = '0;
    access_size      = SIZE_8;
    pop_count        = 0;
    read_pulses      = 0;
    error_count      = 0;
    test_errors      = 0;
    test_num         = 0;
    reads_done       = 0;
    refresh_fifo();
    repeat (4) @(posedge clk);
    #1;
    areset = 1'b0;

    check_level("wait after reset", access_wait, 1'b0);
    check_level("dv after reset", access_dv, 1'b0);
    check_level("FIFO pop after reset", fifo_rd_en, 1'b0);
    check_level("packet read after reset", packet_read, 1'b0);
    check_word("read data after reset", access_data, '0);
    end_test("reset values");

    load_packet(16, 0);
    for (i = 0; i < 16; i++) begin
      read_and_check(11'(i * 8), SIZE_64);
    end
    end_test("16-word load and aligned reads");

    for (i = 0; i < 16; i++) begin
      for (s = 0; s < 4; s++) begin
        size = word_size_t'(s);
        for (off = 0; off + read_length(size) <= 8; off++) begin
          read_and_check(11'(i * 8 + off), size);
        end
      end
    end
    end_test("reads inside one word");

    read_and_check(11'(4 * 8 + 7), SIZE_16);
    for (off = 5; off < 8; off++) begin
      read_and_check(11'(4 * 8 + off), SIZE_32);
    end
    for (off = 1; off < 8; off++) begin
      read_and_check(11'(9 * 8 + off), SIZE_64);
    end
    // Random reads stay inside the 16 loaded words
    for (i = 0; i < 200; i++) begin
      size = word_size_t'($urandom_range(0, 3));
      read_and_check(11'($urandom_range(0, 128 - read_length(size))), size);
    end
    end_test("word-crossing and random reads");

    load_packet(6, 20);
    end_test("load held off while the parser is busy");

    for (i = 0; i < 16; i++) begin
      read_and_check(11'(i * 8), SIZE_64);
    end
    // Spans the last new word and the first old one
    read_and_check(11'(5 * 8 + 4), SIZE_64);
    end_test("shorter packet overwrites from word 0");

    $display("%0d tests, %0d reads, %0d errors", test_num, reads_done, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+bench
source/rx_buffer_pkg.sv
source/rx_word_ram.sv
source/rx_fifo_loader.sv
source/rx_buffer_ctrl.sv
source/rx_read_align.sv
source/rx_buffer_top.sv
bench/rx_buffer_tb.sv

// File: source/rx_buffer_ctrl.sv
`timescale 1ns/1ns

module rx_buffer_ctrl import rx_buffer_pkg::*; #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,
  input  logic                  i_dispatch_packet_available,
  input  logic                  i_dispatch_fifo_empty,
  input  logic                  i_parser_busy,
  input  logic                  i_load_done,
  input  logic                  i_access_port_rd_en,
  input  logic [ADDR_WIDTH+2:0] i_access_port_addr,
  input  word_size_t            i_access_port_wordsize,
  output logic                  o_load,
  output logic [ADDR_WIDTH-1:0] o_rd_addr,
  output access_sel_t           o_sel,
  output read_phase_t           o_phase,
  output logic                  o_access_port_wait
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        load_start;
  logic        read_accept;
  logic        req_crosses;

  assign load_start = (state == ST_IDLE) && i_dispatch_packet_available &&
                      !i_dispatch_fifo_empty && !i_parser_busy;

  // A load starting in the same cycle wins over a read request
  assign read_accept = (state == ST_IDLE) && !load_start && i_access_port_rd_en;

  // Read spills into the next word when offset plus length passes 8
  assign req_crosses = ({1'b0, i_access_port_addr[2:0]} +
                        size_bytes(i_access_port_wordsize)) > BYTES_PER_WORD;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (load_start) begin
          state_next = ST_LOAD;
        end else if (read_accept) begin
          state_next = req_crosses ? ST_READ_NEXT : ST_READ_WAIT;
        end
      end
      ST_LOAD: begin
        if (i_load_done) begin
          state_next = ST_IDLE;
        end
      end
      ST_READ_WAIT:  state_next = ST_READ_WHOLE;
      ST_READ_WHOLE: state_next = ST_IDLE;
      ST_READ_NEXT:  state_next = ST_READ_HEAD;
      ST_READ_HEAD:  state_next = ST_READ_TAIL;
      ST_READ_TAIL:  state_next = ST_IDLE;
      default:       state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state              <= ST_IDLE;
      o_access_port_wait <= 1'b0;
    end else begin
      state <= state_next;
      // Wait drops at the same edge the aligner raises dv
      if (read_accept) begin
        o_access_port_wait <= 1'b1;
      end else if (state == ST_READ_WHOLE || state == ST_READ_TAIL) begin
        o_access_port_wait <= 1'b0;
      end
    end
  end

  // Request address and selection are held for the whole read
  always_ff @(posedge i_clk) begin
    if (read_accept) begin
      o_rd_addr    <= i_access_port_addr[ADDR_WIDTH+2:3];
      o_sel.size   <= i_access_port_wordsize;
      o_sel.offset <= i_access_port_addr[2:0];
    end else if (state == ST_READ_NEXT) begin
      // First word is already being read so move on to the second
      o_rd_addr <= o_rd_addr + 1'b1;
    end
  end

  // --------------------------------------------------
  // Outputs to loader and aligner
  // --------------------------------------------------

  assign o_load = (state == ST_LOAD);

  always_comb begin
    case (state)
      ST_READ_WHOLE: o_phase = PH_WHOLE;
      ST_READ_HEAD:  o_phase = PH_HEAD;
      ST_READ_TAIL:  o_phase = PH_TAIL;
      default:       o_phase = PH_NONE;
    endcase
  end

  // Wait is high exactly while a read is in progress
  a_wait_during_read : assert property (
    @(posedge i_clk) disable iff (i_areset)
    o_access_port_wait == !(state inside {ST_IDLE, ST_LOAD})
  );

endmodule

// File: source/rx_buffer_pkg.sv
package rx_buffer_pkg;

  // --------------------------------------------------
  // Word and request types
  // --------------------------------------------------

  localparam int BYTES_PER_WORD = 8;

  typedef logic [8*BYTES_PER_WORD-1:0] word_t;

  // Encoding matches the 2-bit wordsize port of the parser
  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2,
    SIZE_64 = 2'd3
  } word_size_t;

  typedef struct packed {
    word_size_t size;
    logic [2:0] offset;
  } access_sel_t;

  // What the aligner does with the RAM word of this cycle
  typedef enum logic [1:0] {
    PH_NONE,
    PH_WHOLE,
    PH_HEAD,
    PH_TAIL
  } read_phase_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_READ_WAIT,
    ST_READ_WHOLE,
    ST_READ_NEXT,
    ST_READ_HEAD,
    ST_READ_TAIL
  } ctrl_state_t;

  // Number of bytes in a read of the given size, 1 to 8
  function automatic logic [3:0] size_bytes(word_size_t size);
    return 4'd1 << size;
  endfunction

endpackage

// File: source/rx_buffer_top.sv
`timescale 1ns/1ns

module rx_buffer_top import rx_buffer_pkg::*; #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_parser_busy,

  input  logic                  i_dispatch_packet_available,
  output logic                  o_dispatch_packet_read,
  input  logic                  i_dispatch_fifo_empty,
  output logic                  o_dispatch_fifo_rd_en,
  input  word_t                 i_dispatch_fifo_rd_data,

  output logic                  o_access_port_wait,
  input  logic [ADDR_WIDTH+2:0] i_access_port_addr,
  input  word_size_t            i_access_port_wordsize,
  input  logic                  i_access_port_rd_en,
  output logic                  o_access_port_rd_dv,
  output word_t                 o_access_port_rd_data
);

  logic                  load;
  logic                  load_done;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  word_t                 wr_data;
  logic [ADDR_WIDTH-1:0] rd_addr;
  word_t                 rd_data;
  access_sel_t           sel;
  read_phase_t           phase;

  // Write port belongs to the loader, read port to the controller
  rx_word_ram #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram (
    .i_clk     (i_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  rx_fifo_loader #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_loader (
    .i_clk                   (i_clk),
    .i_areset                (i_areset),
    .i_load                  (load),
    .i_dispatch_fifo_empty   (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_data (i_dispatch_fifo_rd_data),
    .o_dispatch_fifo_rd_en   (o_dispatch_fifo_rd_en),
    .o_dispatch_packet_read  (o_dispatch_packet_read),
    .o_load_done             (load_done),
    .o_wr_en                 (wr_en),
    .o_wr_addr               (wr_addr),
    .o_wr_data               (wr_data)
  );

  rx_buffer_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ctrl (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_parser_busy               (i_parser_busy),
    .i_load_done                 (load_done),
    .i_access_port_rd_en         (i_access_port_rd_en),
    .i_access_port_addr          (i_access_port_addr),
    .i_access_port_wordsize      (i_access_port_wordsize),
    .o_load                      (load),
    .o_rd_addr                   (rd_addr),
    .o_sel                       (sel),
    .o_phase                     (phase),
    .o_access_port_wait          (o_access_port_wait)
  );

  rx_read_align u_align (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_sel                 (sel),
    .i_phase               (phase),
    .i_ram_data            (rd_data),
    .o_access_port_rd_dv   (o_access_port_rd_dv),
    .o_access_port_rd_data (o_access_port_rd_data)
  );

endmodule

// File: source/rx_fifo_loader.sv
`timescale 1ns/1ns

module rx_fifo_loader import rx_buffer_pkg::*; #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,
  input  logic                  i_load,
  input  logic                  i_dispatch_fifo_empty,
  input  word_t                 i_dispatch_fifo_rd_data,
  output logic                  o_dispatch_fifo_rd_en,
  output logic                  o_dispatch_packet_read,
  output logic                  o_load_done,
  output logic                  o_wr_en,
  output logic [ADDR_WIDTH-1:0] o_wr_addr,
  output word_t                 o_wr_data
);

  logic                  pop;
  logic [ADDR_WIDTH-1:0] word_cnt;

  // FIFO is first-word-fall-through, so the head word is written
  // in the same cycle it is popped
  assign pop = i_load && !i_dispatch_fifo_empty;

  assign o_dispatch_fifo_rd_en = pop;
  assign o_wr_en               = pop;
  assign o_wr_addr             = word_cnt;
  assign o_wr_data             = i_dispatch_fifo_rd_data;

  // Empty FIFO during a load marks the end of the packet
  assign o_load_done            = i_load && i_dispatch_fifo_empty;
  assign o_dispatch_packet_read = o_load_done;

  // Every packet starts at word 0
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      word_cnt <= '0;
    end else if (!i_load) begin
      word_cnt <= '0;
    end else if (pop) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // Once the end is seen the controller drops the load, so no
  // word may be popped in the cycle after it
  a_no_pop_after_end : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (i_load && i_dispatch_fifo_empty) |=> !o_dispatch_fifo_rd_en
  );

endmodule

// File: source/rx_read_align.sv
`timescale 1ns/1ns

module rx_read_align import rx_buffer_pkg::*; (
  input  logic        i_clk,
  input  logic        i_areset,
  input  access_sel_t i_sel,
  input  read_phase_t i_phase,
  input  word_t       i_ram_data,
  output logic        o_access_port_rd_dv,
  output word_t       o_access_port_rd_data
);

  logic [3:0] len;
  logic [3:0] tail_len;
  logic [6:0] skip_bits;
  logic [6:0] drop_bits;
  logic [6:0] tail_bits;
  logic [6:0] rest_bits;
  word_t      lead_aligned;
  word_t      whole_data;
  word_t      head_data;
  word_t      tail_data;
  word_t      hold;

  assign len = size_bytes(i_sel.size);

  // Bytes taken from the second word of a crossing read
  assign tail_len = len + {1'b0, i_sel.offset} - 4'(BYTES_PER_WORD);

  assign skip_bits = {1'b0, i_sel.offset, 3'b000};
  assign drop_bits = {4'(BYTES_PER_WORD) - len, 3'b000};
  assign tail_bits = {tail_len, 3'b000};
  assign rest_bits = 7'd64 - tail_bits;

  // --------------------------------------------------
  // Byte extraction
  // --------------------------------------------------

  // Big-endian words, byte at the offset moved to the top
  assign lead_aligned = i_ram_data << skip_bits;

  // Top len bytes brought down to the low end
  assign whole_data = lead_aligned >> drop_bits;

  // Offset to end of the first word, right-aligned
  assign head_data = lead_aligned >> skip_bits;

  // Head bytes moved up, leading bytes of the second word below
  assign tail_data = (hold << tail_bits) | (i_ram_data >> rest_bits);

  always_ff @(posedge i_clk) begin
    if (i_phase == PH_HEAD) begin
      hold <= head_data;
    end
  end

  // --------------------------------------------------
  // Result register
  // --------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_access_port_rd_dv   <= 1'b0;
      o_access_port_rd_data <= '0;
    end else begin
      o_access_port_rd_dv <= 1'b0;
      case (i_phase)
        PH_WHOLE: begin
          o_access_port_rd_dv   <= 1'b1;
          o_access_port_rd_data <= whole_data;
        end
        PH_TAIL: begin
          o_access_port_rd_dv   <= 1'b1;
          o_access_port_rd_data <= tail_data;
        end
        default: begin
          // Result holds until the next read finishes
        end
      endcase
    end
  end

  // Controller must route every crossing read through head and tail
  a_whole_fits : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (i_phase == PH_WHOLE) |-> ({1'b0, i_sel.offset} + len) <= BYTES_PER_WORD
  );

endmodule

// File: source/rx_word_ram.sv
`timescale 1ns/1ns

module rx_word_ram import rx_buffer_pkg::*; #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_wr_en,
  input  logic [ADDR_WIDTH-1:0] i_wr_addr,
  input  word_t                 i_wr_data,
  input  logic [ADDR_WIDTH-1:0] i_rd_addr,
  output word_t                 o_rd_data
);

  // Packet storage, one 64-bit word per entry
  word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Registered read port, data follows the address by one clock
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule
